// ==== dv/fetch_patterns.txt ====
# M <word address> <64-bit word>    memory image, other words use a fill pattern
# E <address>                       word answers with err
# N <count>                         consume count instructions
# R <count> <target>                consume count instructions, then redirect
# S <cycles>                        decode stalls, G <cycles> grants withheld
M 80000000 4581450100000513
M 80000008 0085051300b50533
M 80000010 0513450100000297
M 80000018 4685467500004605
M 80000020 fe0718e390028082
M 80000028 00c5856345814501
M 80000030 8082050500050513
M 80000038 0000006f4505f06f
M 80000040 1141e4060ff00513
M 80000048 00113423e022c11d
E 80000010
E 80000048
N 14
R 4 80000200
R 5 80000012
R 6 80000024
R 8 80000106
S 60
N 10
G 20
N 10
R 5 80000046
N 12
R 3 80000004
N 16
S 40
N 20

// ==== vlog.f ====
+incdir+include
src/core_fetch_pkg.sv
src/core_pipe_fetch_buffer.sv
src/core_pipe_fetch.sv
src/core_fetch_top.sv
dv/tb_clock_gen.sv
dv/tb_core_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch testbench with Verilator from the project root

verilator --binary --timing -Wall -f vlog.f --top-module tb_core_fetch -o sim_tb \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 || { echo "Simulator exited with an error"; exit 1; }

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "No pass result in sim.log"; exit 1; }
echo "Simulation passed"

// ==== dv/tb_core_fetch.sv ====
// ----------------------------------------------------------
// Testbench for the fetch front end. Models the instruction
// memory and the decoder, runs the script from the pattern
// file and checks every consumed instruction against a PC
// walker over the same memory image.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_core_fetch
    import core_fetch_pkg::*;
();

    logic       g_clk;
    logic       g_resetn;
    logic       cf_valid;
    cf_req_t    cf_req;
    logic       cf_ack;
    logic       imem_req;
    xlen_t      imem_addr;
    logic       imem_gnt;
    imem_rsp_t  imem_rsp;
    fetch_out_t fetch_out;
    logic       eat_2;
    logic       eat_4;

    tb_clock_gen u_clk (
        .g_clk    (g_clk),
        .g_resetn (g_resetn)
    );

    core_fetch_top uut (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_valid  (cf_valid),
        .cf_req    (cf_req),
        .cf_ack    (cf_ack),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_gnt  (imem_gnt),
        .imem_rsp  (imem_rsp),
        .fetch_out (fetch_out),
        .eat_2     (eat_2),
        .eat_4     (eat_4)
    );

    // ------------------------------------------------------
    // Memory image and script
    // ------------------------------------------------------

    mem_data_t mem_img [xlen_t];            // Words by aligned address
    bit        err_img [xlen_t];            // Words that answer with err
    byte       script_op [$];
    xlen_t     script_a  [$];
    xlen_t     script_b  [$];

    int        errors;
    int        checks;
    bit        aborted;                     // A wait ran out of time
    xlen_t     ref_pc;                      // Reference walker PC
    imem_rsp_t pend_rsp;                    // Answer for the last grant
    bit        rsp_pend;
    bit        grant_hold;
    bit        target_chk;                  // Check target after redirect
    xlen_t     target_q;

    function automatic mem_data_t mem_word(input xlen_t addr);
        xlen_t a;
        a = {addr[63:3], 3'b000};
        if (mem_img.exists(a)) begin
            return mem_img[a];
        end
        return {a[31:0] ^ 32'h3c5a_96e1, a[63:32] ^ (a[31:0] * 32'h9e37_79b1)};
    endfunction

    function automatic bit word_err(input xlen_t addr);
        xlen_t a;
        a = {addr[63:3], 3'b000};
        return err_img.exists(a);
    endfunction

    function automatic logic [15:0] ref_half(input xlen_t addr);
        mem_data_t w;
        w = mem_word(addr);
        return w[addr[2:1]*16 +: 16];       // Halfword within the word
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic read_patterns();
        int    fd;
        int    n;
        byte   op;
        xlen_t a;
        xlen_t b;
        string line;
        fd = $fopen("dv/fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file dv/fetch_patterns.txt");
            aborted = 1'b1;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            b = '0;
            n = $sscanf(line, "%c %h %h", op, a, b);
            if (n >= 2) begin
                case (op)
                    "M": mem_img[a] = b;
                    "E": err_img[{a[63:3], 3'b000}] = 1'b1;
                    "R", "N", "S", "G": begin
                        script_op.push_back(op);
                        script_a.push_back(a);
                        script_b.push_back(b);
                    end
                    default: ;                  // Comment lines
                endcase
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------
    // One clock of memory model and decoder
    // ------------------------------------------------------

    task automatic check_and_eat();
        logic [15:0] h0;
        logic [15:0] h1;
        bit          is32;
        h0   = ref_half(ref_pc);
        h1   = ref_half(ref_pc + 2);
        is32 = (h0[1:0] == 2'b11);
        check_value("i32bit", fetch_out.i32bit, is32);
        check_value("i16bit", fetch_out.i16bit, !is32);
        check_value("pc", fetch_out.pc, ref_pc);
        check_value("npc", fetch_out.npc, ref_pc + (is32 ? 4 : 2));
        if (is32) begin
            check_value("instr", fetch_out.instr, {h1, h0});
            check_value("ferr", fetch_out.ferr, {word_err(ref_pc + 2), word_err(ref_pc)});
        end else begin
            check_value("instr[15:0]", fetch_out.instr[15:0], h0);
            check_value("ferr[0]", fetch_out.ferr[0], word_err(ref_pc));
        end
        eat_2  = fetch_out.i16bit;              // Only while presented
        eat_4  = fetch_out.i32bit;
        ref_pc = ref_pc + (is32 ? 4 : 2);
    endtask

    task automatic step_cycle(input bit allow_eat, output bit ate);
        bit deliver;
        @(negedge g_clk);
        ate      = 1'b0;
        cf_valid = 1'b0;
        eat_2    = 1'b0;
        eat_4    = 1'b0;
        if (target_chk) begin
            check_value("imem_addr after redirect", imem_addr, target_q);
            check_value("pc after redirect", fetch_out.pc, target_q);
            target_chk = 1'b0;
        end
        deliver = rsp_pend;
        if (deliver) begin
            imem_rsp = pend_rsp;                // One cycle after grant
        end
        imem_gnt = !grant_hold && ($urandom_range(0, 3) != 0);
        rsp_pend = imem_req && imem_gnt;
        if (rsp_pend) begin
            pend_rsp.rdata = mem_word(imem_addr);
            pend_rsp.err   = word_err(imem_addr);
        end
        if (allow_eat && (fetch_out.i16bit || fetch_out.i32bit)
                && ($urandom_range(0, 2) != 0)) begin
            check_and_eat();
            ate = 1'b1;
        end
    endtask

    // ------------------------------------------------------
    // Script commands
    // ------------------------------------------------------

    task automatic consume(input int count);
        int limit;
        int done;
        bit ate;
        limit = 60 * count + 100;
        done  = 0;
        while (done < count && limit > 0) begin
            step_cycle(1'b1, ate);
            if (ate) done++;
            limit--;
        end
        if (done < count) begin
            $display("Timed out waiting for decode to consume %0d instructions", count);
            aborted = 1'b1;
        end
    endtask

    task automatic redirect(input xlen_t target);
        int limit;
        bit ate;
        bit taken;
        limit        = 50;
        taken        = 1'b0;
        cf_req.target = target;
        cf_req.cause  = cf_cause_t'($urandom);   // No function in fetch
        while (!taken && limit > 0) begin
            step_cycle(1'b0, ate);
            cf_valid = 1'b1;
            #1;
            taken = cf_ack;                     // Gnt already set this cycle
            // Held off only by a request still waiting for its grant
            check_value("cf_ack", cf_ack, !(imem_req && !imem_gnt));
            limit--;
        end
        if (!taken) begin
            $display("Timed out waiting for the redirect to be acknowledged");
            aborted = 1'b1;
        end else begin
            ref_pc     = target;
            target_q   = target;
            target_chk = 1'b1;
        end
    endtask

    task automatic stall_decode(input int cycles);
        bit ate;
        repeat (cycles) step_cycle(1'b0, ate);
        check_value("imem_req with full buffer", imem_req, 1'b0);
    endtask

    task automatic stall_grant(input int cycles);
        bit    ate;
        xlen_t held;
        grant_hold = 1'b1;
        step_cycle(1'b1, ate);
        held = imem_addr;
        repeat (cycles) begin
            step_cycle(1'b1, ate);
            check_value("imem_addr without grant", imem_addr, held);
        end
        grant_hold = 1'b0;
    endtask

    // ------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------

    initial begin
        int limit;
        int i;
        bit released;
        cf_valid   = 1'b0;
        cf_req     = '0;
        imem_gnt   = 1'b0;
        imem_rsp   = '0;
        eat_2      = 1'b0;
        eat_4      = 1'b0;
        errors     = 0;
        checks     = 0;
        aborted    = 1'b0;
        rsp_pend   = 1'b0;
        pend_rsp   = '0;
        grant_hold = 1'b0;
        target_chk = 1'b0;
        ref_pc     = `CORE_PC_RESET_ADDRESS;
        void'($urandom(73616));
        read_patterns();

        limit    = 0;
        released = 1'b0;
        while (!released && limit < 100) begin
            @(negedge g_clk);
            if (limit == 4) begin             // Reset has been seen
                check_value("imem_req in reset", imem_req, 1'b0);
                check_value("i16bit in reset", fetch_out.i16bit, 1'b0);
                check_value("i32bit in reset", fetch_out.i32bit, 1'b0);
                check_value("pc in reset", fetch_out.pc, `CORE_PC_RESET_ADDRESS);
                check_value("imem_addr in reset", imem_addr, `CORE_PC_RESET_ADDRESS);
                check_value("cf_ack in reset", cf_ack, 1'b1);
            end
            released = (g_resetn === 1'b1);
            limit++;
        end
        if (!released) begin
            $display("Reset was never released");
            aborted = 1'b1;
        end

        for (i = 0; i < script_op.size() && !aborted; i++) begin
            case (script_op[i])
                "N": consume(int'(script_a[i]));
                "R": begin
                    consume(int'(script_a[i]));
                    if (!aborted) redirect(script_b[i]);
                end
                "S": stall_decode(int'(script_a[i]));
                "G": stall_grant(int'(script_a[i]));
                default: ;
            endcase
        end

        $display("Run summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !aborted) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// ----------------------------------------------------------
// Testbench clock and reset. 8 ns period, synchronous
// active low reset held for 10 cycles, released on a
// falling edge.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic g_clk,
    output logic g_resetn
);

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;          // 8 ns period
    end

    initial begin
        g_resetn = 1'b0;
        repeat (10) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;                    // Release away from the active edge
    end

endmodule

`default_nettype wire

// ==== src/core_fetch_top.sv ====
// ----------------------------------------------------------
// Fetch subsystem top. Presents the redirect, instruction
// memory and decode channels as packed structs and holds
// the fetch stage.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module core_fetch_top
    import core_fetch_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,

    // Redirect channel
    input  logic       cf_valid,
    input  cf_req_t    cf_req,
    output logic       cf_ack,

    // Instruction memory, read only
    output logic       imem_req,
    output xlen_t      imem_addr,
    input  logic       imem_gnt,
    input  imem_rsp_t  imem_rsp,

    // Decode channel
    output fetch_out_t fetch_out,
    input  logic       eat_2,
    input  logic       eat_4
);

    // ------------------------------------------------------
    // Fetch stage
    // ------------------------------------------------------

    core_pipe_fetch u_fetch (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .cf_valid  (cf_valid),
        .cf_req    (cf_req),
        .cf_ack    (cf_ack),
        .imem_req  (imem_req),
        .imem_addr (imem_addr),
        .imem_gnt  (imem_gnt),
        .imem_rsp  (imem_rsp),          // Err and data of last grant
        .fetch_out (fetch_out),
        .eat_2     (eat_2),
        .eat_4     (eat_4)
    );

endmodule

`default_nettype wire

// ==== src/core_pipe_fetch.sv ====
// ----------------------------------------------------------
// Fetch stage. Issues aligned 8-byte reads, follows
// redirects, drops stale responses and presents one 16 or
// 32 bit instruction from the fetch buffer to decode.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_fetch_config.svh"

module core_pipe_fetch
    import core_fetch_pkg::*;
(
    input  logic       g_clk,
    input  logic       g_resetn,

    input  logic       cf_valid,        // Redirect request
    input  cf_req_t    cf_req,          // Target and cause
    output logic       cf_ack,          // Redirect taken when both high

    output logic       imem_req,        // Registered read request
    output xlen_t      imem_addr,       // Held until grant
    input  logic       imem_gnt,
    input  imem_rsp_t  imem_rsp,        // Valid one cycle after grant

    output fetch_out_t fetch_out,       // Instruction to decode
    input  logic       eat_2,           // Decode takes 2 bytes
    input  logic       eat_4            // Decode takes 4 bytes
);

    // ------------------------------------------------------
    // Events
    // ------------------------------------------------------

    logic        e_cf_change;           // Redirect this cycle
    logic        e_imem_req;            // Request accepted
    logic        imem_recv;             // Response on the bus now

    logic        i16bit;
    logic        i32bit;
    logic        buf_drain_2;
    logic        buf_drain_4;

    assign e_cf_change = cf_valid && cf_ack;
    assign e_imem_req  = imem_req && imem_gnt;

    // Only redirect when no request would be left half issued
    assign cf_ack      = !imem_req || imem_gnt;

    // ------------------------------------------------------
    // Fetch address and request
    // ------------------------------------------------------

    fbuf_depth_t buf_depth;             // Bytes held now
    fbuf_depth_t n_buf_depth;           // Bytes held next cycle
    logic        buf_ready;
    xlen_t       n_imem_addr;

    // One word in flight at a time keeps depth at most 12
    assign buf_ready   = n_buf_depth <= fbuf_depth_t'(4);
    assign n_imem_addr = {imem_addr[`CORE_XLEN-1:3], 3'b000} + xlen_t'(8);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            imem_req  <= 1'b0;
            imem_recv <= 1'b0;
            imem_addr <= `CORE_PC_RESET_ADDRESS;
        end else begin
            imem_req  <= buf_ready && !e_imem_req;
            imem_recv <= e_imem_req;
            if (e_cf_change) begin
                imem_addr <= cf_req.target;     // Unaligned target kept as is
            end else if (e_imem_req) begin
                imem_addr <= n_imem_addr;       // Next aligned word
            end
        end
    end

    // ------------------------------------------------------
    // Decode PC
    // ------------------------------------------------------

    xlen_t pc;
    xlen_t n_pc;

    assign n_pc = pc + xlen_t'({i32bit, i16bit, 1'b0});      // +4 or +2

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= `CORE_PC_RESET_ADDRESS;
        end else if (e_cf_change) begin
            pc <= cf_req.target;
        end else if (buf_drain_2 || buf_drain_4) begin
            pc <= n_pc;
        end
    end

    // ------------------------------------------------------
    // Stale response dropping
    // ------------------------------------------------------

    logic [1:0] reqs_outstanding;       // Accepted, not yet answered
    logic [1:0] n_reqs_outstanding;
    logic [1:0] rsps_ignore;            // Left to drop after redirect
    logic       ignore_rsp;

    assign n_reqs_outstanding = reqs_outstanding + {1'b0, e_imem_req}
                              - {1'b0, imem_recv};
    assign ignore_rsp         = |rsps_ignore;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            reqs_outstanding <= 2'b00;
            rsps_ignore      <= 2'b00;
        end else begin
            reqs_outstanding <= n_reqs_outstanding;
            if (e_cf_change) begin
                rsps_ignore <= n_reqs_outstanding;  // All still in flight are stale
            end else if (imem_recv && ignore_rsp) begin
                rsps_ignore <= rsps_ignore - 2'd1;
            end
        end
    end

    // ------------------------------------------------------
    // Fill strobes
    // ------------------------------------------------------

    logic       first_pend;             // Next grant is the target word
    logic [1:0] first_off;              // Halfword offset of the target
    logic       buf_fill_2;
    logic       buf_fill_4;
    logic       buf_fill_6;
    logic       buf_fill_8;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            first_pend <= 1'b0;
            first_off  <= 2'b00;
        end else if (e_cf_change) begin
            first_pend <= 1'b1;
            first_off  <= cf_req.target[2:1];
        end else if (e_imem_req) begin
            first_pend <= 1'b0;
        end
    end

    // Latched on grant so they line up with the response
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            buf_fill_2 <= 1'b0;
            buf_fill_4 <= 1'b0;
            buf_fill_6 <= 1'b0;
            buf_fill_8 <= 1'b0;
        end else if (e_imem_req && !e_cf_change) begin
            buf_fill_2 <= first_pend && (first_off == 2'd3);
            buf_fill_4 <= first_pend && (first_off == 2'd2);
            buf_fill_6 <= first_pend && (first_off == 2'd1);
            buf_fill_8 <= !first_pend || (first_off == 2'd0);
        end
    end

    // ------------------------------------------------------
    // Buffer and length detection
    // ------------------------------------------------------

    logic   buf_fill_en;
    instr_t buf_data_out;
    ferr_t  buf_error_out;

    assign buf_fill_en = imem_recv && !ignore_rsp;
    assign buf_drain_2 = i16bit && eat_2;
    assign buf_drain_4 = i32bit && eat_4;

    assign i16bit = (buf_depth >= fbuf_depth_t'(2)) && (buf_data_out[1:0] != 2'b11);
    assign i32bit = (buf_depth >= fbuf_depth_t'(4)) && (buf_data_out[1:0] == 2'b11);

    assign fetch_out.i16bit = i16bit;
    assign fetch_out.i32bit = i32bit;
    assign fetch_out.instr  = buf_data_out;
    assign fetch_out.pc     = pc;
    assign fetch_out.npc    = n_pc;
    assign fetch_out.ferr   = buf_error_out;

    core_pipe_fetch_buffer u_fetch_buffer (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .flush     (e_cf_change),       // Redirect empties the buffer
        .data_in   (imem_rsp.rdata),
        .error_in  (imem_rsp.err),
        .fill_en   (buf_fill_en),
        .fill_2    (buf_fill_2),
        .fill_4    (buf_fill_4),
        .fill_6    (buf_fill_6),
        .fill_8    (buf_fill_8),
        .drain_2   (buf_drain_2),
        .drain_4   (buf_drain_4),
        .depth     (buf_depth),
        .n_depth   (n_buf_depth),
        .data_out  (buf_data_out),
        .error_out (buf_error_out)
    );

endmodule

`default_nettype wire

// ==== src/core_pipe_fetch_buffer.sv ====
// ----------------------------------------------------------
// Byte-granular fetch buffer. Appends the top 2/4/6/8 bytes
// of a memory word and drains 2 or 4 bytes from the bottom,
// both in one cycle if needed. Error tags per halfword.
// ----------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "core_fetch_config.svh"

module core_pipe_fetch_buffer
    import core_fetch_pkg::*;
(
    input  logic        g_clk,
    input  logic        g_resetn,
    input  logic        flush,          // Drop all contents
    input  mem_data_t   data_in,        // Memory word
    input  logic        error_in,       // Word came back with err
    input  logic        fill_en,
    input  logic        fill_2,         // Top 2 bytes of data_in
    input  logic        fill_4,         // Top 4 bytes
    input  logic        fill_6,         // Top 6 bytes
    input  logic        fill_8,         // Whole word
    input  logic        drain_2,
    input  logic        drain_4,
    output fbuf_depth_t depth,          // Bytes held
    output fbuf_depth_t n_depth,        // Bytes held next cycle
    output instr_t      data_out,       // Lowest 4 bytes
    output ferr_t       error_out       // Tags of lowest 2 halfwords
);

    localparam int BUF_W  = `CORE_FBUF_BYTES * 8;
    localparam int BUF_HW = `CORE_FBUF_BYTES / 2;

    // ------------------------------------------------------
    // Storage
    // ------------------------------------------------------

    logic [BUF_W-1:0]  data_q;          // Byte 0 is next to decode
    logic [BUF_HW-1:0] err_q;

    // ------------------------------------------------------
    // Next state
    // ------------------------------------------------------

    fbuf_depth_t       drain_bytes;
    fbuf_depth_t       d_after;         // Depth once drained
    fbuf_depth_t       fill_bytes;
    mem_data_t         fill_word;       // Selected bytes, right aligned
    logic [3:0]        fill_hw;         // Halfwords being appended
    logic [BUF_W-1:0]  keep_mask;
    logic [BUF_W-1:0]  n_data;
    logic [BUF_HW-1:0] err_keep;
    logic [BUF_HW-1:0] n_err;

    always_comb begin
        drain_bytes = '0;
        if (drain_4) begin
            drain_bytes = fbuf_depth_t'(4);
        end else if (drain_2) begin
            drain_bytes = fbuf_depth_t'(2);
        end
        d_after = depth - drain_bytes;

        fill_word  = '0;
        fill_bytes = '0;
        fill_hw    = 4'b0000;
        if (fill_en) begin
            if (fill_8) begin
                fill_word  = data_in;
                fill_bytes = fbuf_depth_t'(8);
                fill_hw    = 4'b1111;
            end else if (fill_6) begin
                fill_word  = data_in >> 16;     // Skip the low halfword
                fill_bytes = fbuf_depth_t'(6);
                fill_hw    = 4'b0111;
            end else if (fill_4) begin
                fill_word  = data_in >> 32;
                fill_bytes = fbuf_depth_t'(4);
                fill_hw    = 4'b0011;
            end else if (fill_2) begin
                fill_word  = data_in >> 48;
                fill_bytes = fbuf_depth_t'(2);
                fill_hw    = 4'b0001;
            end
        end

        // Shift down, keep what is left, append above it
        keep_mask = ~({BUF_W{1'b1}} << {d_after, 3'b000});
        n_data    = ((data_q >> {drain_bytes, 3'b000}) & keep_mask)
                  | (BUF_W'(fill_word) << {d_after, 3'b000});

        err_keep  = ~({BUF_HW{1'b1}} << d_after[4:1]);
        n_err     = ((err_q >> drain_bytes[4:1]) & err_keep)
                  | (BUF_HW'({4{error_in}} & fill_hw) << d_after[4:1]);

        if (flush) begin
            n_depth = '0;                       // Flush beats any fill
        end else begin
            n_depth = d_after + fill_bytes;
        end
    end

    // ------------------------------------------------------
    // Registers
    // ------------------------------------------------------

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            depth <= '0;
        end else begin
            depth <= n_depth;
        end
    end

    always_ff @(posedge g_clk) begin
        if (flush) begin
            data_q <= '0;
            err_q  <= '0;
        end else begin
            data_q <= n_data;
            err_q  <= n_err;
        end
    end

    assign data_out  = data_q[31:0];
    assign error_out = err_q[1:0];

endmodule

`default_nettype wire

// ==== src/core_fetch_pkg.sv ====
// ----------------------------------------------------------
// Shared types for the fetch front end and its testbench.
// Widths come from the config header.
// ----------------------------------------------------------

`default_nettype none

`include "core_fetch_config.svh"

package core_fetch_pkg;

    // ------------------------------------------------------
    // Width types
    // ------------------------------------------------------

    typedef logic [`CORE_XLEN-1:0]       xlen_t;       // Address or PC
    typedef logic [`CORE_MEM_DATA_W-1:0] mem_data_t;   // Memory word
    typedef logic [31:0]                 instr_t;      // Window to decode
    typedef logic [1:0]                  ferr_t;       // Error bit per halfword
    typedef logic [`CORE_CF_CAUSE_W-1:0] cf_cause_t;

    // Holds 0 up to full capacity, so one extra value
    typedef logic [$clog2(`CORE_FBUF_BYTES+1)-1:0] fbuf_depth_t;

    // ------------------------------------------------------
    // Channel bundles
    // ------------------------------------------------------

    typedef struct packed {
        xlen_t     target;      // Redirect destination
        cf_cause_t cause;       // Carried along, unused by fetch
    } cf_req_t;

    typedef struct packed {
        logic      err;         // Bus error on this word
        mem_data_t rdata;       // Read data, whole aligned word
    } imem_rsp_t;

    typedef struct packed {
        logic      i16bit;      // Compressed instr present
        logic      i32bit;      // Full width instr present
        instr_t    instr;       // Low bytes of the buffer
        xlen_t     pc;          // PC of instr
        xlen_t     npc;         // PC after instr
        ferr_t     ferr;        // Fetch error per halfword
    } fetch_out_t;

endpackage

`default_nettype wire

// ==== include/core_fetch_config.svh ====
// ----------------------------------------------------------
// Build-time constants for the instruction fetch front end.
// Included by the package and by any RTL that needs a raw
// value; the package turns the widths into types.
// ----------------------------------------------------------

`ifndef CORE_FETCH_CONFIG_SVH
`define CORE_FETCH_CONFIG_SVH

// ----------------------------------------------------------
// Architectural
// ----------------------------------------------------------

// First PC fetched after reset
`define CORE_PC_RESET_ADDRESS 64'h0000_0000_8000_0000

`define CORE_XLEN             64        // Address and PC width

// ----------------------------------------------------------
// Fetch path sizing
// ----------------------------------------------------------

`define CORE_MEM_DATA_W       64        // One aligned memory word

`define CORE_CF_CAUSE_W       7         // Redirect cause field

// Fetch buffer capacity in bytes, two memory words
`define CORE_FBUF_BYTES       16

`endif
